/* source/pes_pkg.sv */
package pes_pkg;

  localparam int TS_WIDTH       = 33;
  localparam int BYTE_WIDTH     = 8;
  localparam int TS_FIELD_BYTES = 5; // bytes in one PTS or DTS field

  localparam logic [BYTE_WIDTH-1:0] STUFF_BYTE = 8'hFF;
  localparam logic [BYTE_WIDTH-1:0] NO_TS_BYTE = 8'h0F; // header carries no timestamp

  // high nibble of the first field byte
  localparam logic [3:0] PREFIX_PTS     = 4'b0010;
  localparam logic [3:0] PREFIX_PTS_DTS = 4'b0011;
  localparam logic [3:0] PREFIX_DTS     = 4'b0001; // second field of a PTS and DTS header

  // time_bytes codes reported with done
  localparam logic [3:0] TB_NONE    = 4'd1;
  localparam logic [3:0] TB_PTS     = 4'd5;
  localparam logic [3:0] TB_PTS_DTS = 4'd10;
  localparam logic [3:0] TB_ERROR   = 4'd0;

  typedef enum logic [1:0]
  {
    kind_none,
    kind_pts,
    kind_pts_dts,
    kind_bad
  } header_kind_e;

  typedef enum logic [2:0]
  {
    st_idle,
    st_search,
    st_pts,
    st_dts,
    st_done
  } seq_state_e;

endpackage

/* source/pes_byte_if.sv */
`timescale 1ns/1ps

interface pes_byte_if;

  logic [pes_pkg::BYTE_WIDTH-1:0] data;
  logic                           valid;
  logic                           ready;
  logic                           start; // held high for the whole header exchange

  modport source
  (
    output data,
    output valid,
    output start,
    input  ready
  );

  // only the sequencer drives ready, the other blocks read it to see accepted bytes
  modport sink
  (
    input  data,
    input  valid,
    input  start,
    output ready
  );

endinterface

/* source/header_byte_classifier.sv */
`timescale 1ns/1ps

module header_byte_classifier #(
  parameter int MAX_STUFFING = 16
) (
  input  logic                 read_signal,
  input  logic                 rst,
  pes_byte_if.sink             bus,
  input  logic                 header_reset,
  output pes_pkg::header_kind_e kind,
  output logic                 kind_hit,
  output logic                 stuff_overflow
);

  localparam int COUNT_WIDTH = $clog2(MAX_STUFFING + 2);
  localparam logic [COUNT_WIDTH-1:0] COUNT_MAX = COUNT_WIDTH'(MAX_STUFFING);

  logic [COUNT_WIDTH-1:0] stuff_count;
  logic                   found;    // first non-stuffing byte already seen
  logic                   accept;
  logic                   is_stuff;

  assign accept   = bus.valid && bus.ready;
  assign is_stuff = (bus.data == pes_pkg::STUFF_BYTE);

  assign kind_hit       = accept && !found && !is_stuff;
  assign stuff_overflow = accept && !found && is_stuff && (stuff_count == COUNT_MAX);

  always_comb
  begin
    if (bus.data == pes_pkg::NO_TS_BYTE)
      kind = pes_pkg::kind_none;
    else if (bus.data[7:4] == pes_pkg::PREFIX_PTS)
      kind = pes_pkg::kind_pts;
    else if (bus.data[7:4] == pes_pkg::PREFIX_PTS_DTS)
      kind = pes_pkg::kind_pts_dts;
    else
      kind = pes_pkg::kind_bad;
  end

  always_ff @(posedge read_signal)
  begin
    if (rst || header_reset)
    begin
      stuff_count <= '0;
      found       <= 1'b0;
    end
    else if (accept && !found)
    begin
      if (!is_stuff)
        found <= 1'b1; // field bytes that follow may hold 0xFF too
      else if (stuff_count != COUNT_MAX)
        stuff_count <= stuff_count + 1'b1;
    end
  end

endmodule

/* source/timestamp_assembler.sv */
`timescale 1ns/1ps

module timestamp_assembler (
  input  logic                         read_signal,
  input  logic                         rst,
  pes_byte_if.sink                     bus,
  input  logic                         header_reset,
  output logic [pes_pkg::TS_WIDTH-1:0] ts_value,
  output logic                         markers_ok,
  output logic [3:0]                   field_prefix
);

  localparam int DEPTH = pes_pkg::TS_FIELD_BYTES - 1;

  // window[0] is the oldest byte, the current bus byte completes the field
  logic [pes_pkg::BYTE_WIDTH-1:0] window [DEPTH];
  logic                           accept;

  assign accept = bus.valid && bus.ready;

  always_ff @(posedge read_signal)
  begin
    if (rst || header_reset)
    begin
      for (int i = 0; i < DEPTH; i++)
        window[i] <= '0;
    end
    else if (accept)
    begin
      for (int i = 0; i < DEPTH - 1; i++)
        window[i] <= window[i + 1];
      window[DEPTH-1] <= bus.data;
    end
  end

  // 3 + 8 + 7 + 8 + 7 bits from the five field bytes
  assign ts_value = {
    window[0][3:1],
    window[1],
    window[2][7:1],
    window[3],
    bus.data[7:1]
  };

  assign markers_ok   = window[0][0] && window[2][0] && bus.data[0];
  assign field_prefix = window[0][7:4];

endmodule

/* source/header_sequencer.sv */
`timescale 1ns/1ps

module header_sequencer (
  input  logic                         read_signal,
  input  logic                         rst,
  pes_byte_if.sink                     bus,
  input  pes_pkg::header_kind_e        kind,
  input  logic                         kind_hit,
  input  logic                         stuff_overflow,
  input  logic [pes_pkg::TS_WIDTH-1:0] ts_value,
  input  logic                         markers_ok,
  input  logic [3:0]                   field_prefix,
  output logic                         header_reset,
  output logic [pes_pkg::TS_WIDTH-1:0] pts,
  output logic [pes_pkg::TS_WIDTH-1:0] dts,
  output logic [3:0]                   time_bytes,
  output logic                         header_error,
  output logic                         done
);

  // the PTS field starts with the classified byte, so four more follow it
  localparam logic [2:0] LAST_PTS = 3'(pes_pkg::TS_FIELD_BYTES - 2);
  localparam logic [2:0] LAST_DTS = 3'(pes_pkg::TS_FIELD_BYTES - 1);

  pes_pkg::seq_state_e          state;
  logic [2:0]                   cnt;
  logic                         dual;   // header carries a DTS field after the PTS
  logic                         accept;
  logic                         finish;
  logic [3:0]                   code;
  logic [pes_pkg::TS_WIDTH-1:0] pts_capture;

  assign bus.ready = bus.start && (state == pes_pkg::st_search ||
                                   state == pes_pkg::st_pts ||
                                   state == pes_pkg::st_dts);

  assign accept       = bus.valid && bus.ready;
  assign header_reset = (state == pes_pkg::st_done) && !bus.start; // clears blocks as done falls

  always_comb
  begin
    finish = 1'b0;
    code   = pes_pkg::TB_ERROR;
    case (state)
      pes_pkg::st_search:
      begin
        if (stuff_overflow)
          finish = 1'b1;
        else if (kind_hit && kind == pes_pkg::kind_none)
        begin
          finish = 1'b1;
          code   = pes_pkg::TB_NONE;
        end
        else if (kind_hit && kind == pes_pkg::kind_bad)
          finish = 1'b1;
      end
      pes_pkg::st_pts:
      begin
        if (accept && cnt == LAST_PTS)
        begin
          if (!markers_ok)
            finish = 1'b1;
          else if (!dual)
          begin
            finish = 1'b1;
            code   = pes_pkg::TB_PTS;
          end
        end
      end
      pes_pkg::st_dts:
      begin
        if (accept && cnt == LAST_DTS)
        begin
          finish = 1'b1;
          if (markers_ok && field_prefix == pes_pkg::PREFIX_DTS)
            code = pes_pkg::TB_PTS_DTS;
        end
      end
      default:
        finish = 1'b0;
    endcase
  end

  always_ff @(posedge read_signal)
  begin
    if (state == pes_pkg::st_pts && accept && cnt == LAST_PTS)
      pts_capture <= ts_value;
  end

  always_ff @(posedge read_signal)
  begin
    if (rst)
    begin
      state        <= pes_pkg::st_idle;
      cnt          <= '0;
      dual         <= 1'b0;
      done         <= 1'b0;
      header_error <= 1'b0;
      time_bytes   <= pes_pkg::TB_ERROR;
      pts          <= '0;
      dts          <= '0;
    end
    else if (finish)
    begin
      state        <= pes_pkg::st_done;
      done         <= 1'b1;
      header_error <= (code == pes_pkg::TB_ERROR);
      time_bytes   <= code;
      if (code == pes_pkg::TB_PTS)
        pts <= ts_value;
      else if (code == pes_pkg::TB_PTS_DTS)
        pts <= pts_capture;
      else
        pts <= '0;
      dts <= (code == pes_pkg::TB_PTS_DTS) ? ts_value : '0;
    end
    else
    begin
      case (state)
        pes_pkg::st_idle:
          if (bus.start)
            state <= pes_pkg::st_search;
        pes_pkg::st_search:
        begin
          if (kind_hit)
          begin
            state <= pes_pkg::st_pts;
            cnt   <= '0;
            dual  <= (kind == pes_pkg::kind_pts_dts);
          end
        end
        pes_pkg::st_pts:
        begin
          if (accept && cnt == LAST_PTS)
          begin
            state <= pes_pkg::st_dts;
            cnt   <= '0;
          end
          else if (accept)
            cnt <= cnt + 1'b1;
        end
        pes_pkg::st_dts:
          if (accept)
            cnt <= cnt + 1'b1;
        pes_pkg::st_done:
        begin
          if (!bus.start)
          begin
            state <= pes_pkg::st_search;
            done  <= 1'b0;
          end
        end
        default:
          state <= pes_pkg::st_idle;
      endcase
    end
  end

endmodule

/* source/pes_timestamp_parser.sv */
`timescale 1ns/1ps

module pes_timestamp_parser #(
  parameter int MAX_STUFFING = 16
) (
  input  logic                           read_signal,
  input  logic                           rst,
  input  logic                           start,
  input  logic [pes_pkg::BYTE_WIDTH-1:0] data_byte,
  input  logic                           byte_valid,
  output logic                           byte_ready,
  output logic                           done,
  output logic                           header_error,
  output logic [3:0]                     time_bytes,
  output logic [pes_pkg::TS_WIDTH-1:0]   pts,
  output logic [pes_pkg::TS_WIDTH-1:0]   dts
);

  pes_byte_if bus ();

  pes_pkg::header_kind_e        kind;
  logic                         kind_hit;
  logic                         stuff_overflow;
  logic [pes_pkg::TS_WIDTH-1:0] ts_value;
  logic                         markers_ok;
  logic [3:0]                   field_prefix;
  logic                         header_reset;

  assign bus.data   = data_byte;
  assign bus.valid  = byte_valid;
  assign bus.start  = start;
  assign byte_ready = bus.ready;

  header_byte_classifier #(
    .MAX_STUFFING (MAX_STUFFING)
  ) u_classifier (
    .read_signal    (read_signal),
    .rst            (rst),
    .bus            (bus),
    .header_reset   (header_reset),
    .kind           (kind),
    .kind_hit       (kind_hit),
    .stuff_overflow (stuff_overflow)
  );

  timestamp_assembler u_assembler (
    .read_signal  (read_signal),
    .rst          (rst),
    .bus          (bus),
    .header_reset (header_reset),
    .ts_value     (ts_value),
    .markers_ok   (markers_ok),
    .field_prefix (field_prefix)
  );

  header_sequencer u_sequencer (
    .read_signal    (read_signal),
    .rst            (rst),
    .bus            (bus),
    .kind           (kind),
    .kind_hit       (kind_hit),
    .stuff_overflow (stuff_overflow),
    .ts_value       (ts_value),
    .markers_ok     (markers_ok),
    .field_prefix   (field_prefix),
    .header_reset   (header_reset),
    .pts            (pts),
    .dts            (dts),
    .time_bytes     (time_bytes),
    .header_error   (header_error),
    .done           (done)
  );

endmodule

/* bench/pes_timestamp_parser_tb.sv */
`timescale 1ns/1ps

module pes_timestamp_parser_tb;

  localparam int MAX_STUFF   = 4;
  localparam int NUM_HEADERS = 300;
  localparam int LIMIT       = 30000; // 300 headers of up to 20 bytes plus gaps

  logic        read_signal;
  logic        rst;
  logic        start;
  logic [7:0]  data_byte;
  logic        byte_valid;
  logic        byte_ready;
  logic        done;
  logic        header_error;
  logic [3:0]  time_bytes;
  logic [32:0] pts;
  logic [32:0] dts;

  logic [7:0]  hdr [$];
  logic [3:0]  exp_tb;
  logic        exp_err;
  logic [32:0] exp_pts;
  logic [32:0] exp_dts;
  string       test_name;
  logic        done_q;
  int          cycles;
  int          compared;
  int          check_errors;
  int          drive_errors;
  int          ns;
  int          sub;
  logic [7:0]  b;
  logic [3:0]  nib;

  pes_timestamp_parser #(
    .MAX_STUFFING (MAX_STUFF)
  ) uut (
    .read_signal  (read_signal),
    .rst          (rst),
    .start        (start),
    .data_byte    (data_byte),
    .byte_valid   (byte_valid),
    .byte_ready   (byte_ready),
    .done         (done),
    .header_error (header_error),
    .time_bytes   (time_bytes),
    .pts          (pts),
    .dts          (dts)
  );

  always #2 read_signal = ~read_signal;

  function automatic logic [32:0] field_value(input logic [7:0] q[$], input int i);
    return {q[i][3:1], q[i+1], q[i+2][7:1], q[i+3], q[i+4][7:1]};
  endfunction

  function automatic logic markers_set(input logic [7:0] q[$], input int i);
    return q[i][0] & q[i+2][0] & q[i+4][0];
  endfunction

  // expected results straight from the header rules, error unless a rule completes
  function automatic void ref_parse(input logic [7:0] q[$], output logic [3:0] tb,
                                    output logic err, output logic [32:0] p,
                                    output logic [32:0] d);
    int idx;
    logic [32:0] pv;
    idx = 0;
    tb  = 4'd0;
    err = 1'b1;
    p   = '0;
    d   = '0;
    while (idx < q.size() && q[idx] == 8'hFF)
      idx++;
    if (idx > MAX_STUFF || idx >= q.size())
      return;
    if (q[idx] == 8'h0F)
    begin
      tb  = 4'd1;
      err = 1'b0;
      return;
    end
    if (q[idx][7:4] != 4'b0010 && q[idx][7:4] != 4'b0011)
      return;
    if (q.size() < idx + 5 || !markers_set(q, idx))
      return;
    pv = field_value(q, idx);
    if (q[idx][7:4] == 4'b0010)
    begin
      tb  = 4'd5;
      err = 1'b0;
      p   = pv;
      return;
    end
    idx += 5;
    if (q.size() < idx + 5 || q[idx][7:4] != 4'b0001 || !markers_set(q, idx))
      return;
    tb  = 4'd10;
    err = 1'b0;
    p   = pv;
    d   = field_value(q, idx);
  endfunction

  function automatic logic [32:0] rand_ts();
    return {1'($urandom_range(0, 1)), $urandom()};
  endfunction

  // bad selects a marker to clear: -1 none, 0 to 2 for bytes 0, 2 and 4
  task automatic add_field(input logic [3:0] prefix, input logic [32:0] ts, input int bad);
    logic [7:0] f [5];
    f[0] = {prefix, ts[32:30], 1'b1};
    f[1] = ts[29:22];
    f[2] = {ts[21:15], 1'b1};
    f[3] = ts[14:7];
    f[4] = {ts[6:0], 1'b1};
    if (bad >= 0)
      f[bad*2][0] = 1'b0;
    foreach (f[i])
      hdr.push_back(f[i]);
  endtask

  task automatic send_byte(input logic [7:0] value);
    int gap;
    gap = $urandom_range(0, 3);
    if (gap > 0)
    begin
      byte_valid <= 1'b0;
      repeat (gap) @(posedge read_signal);
    end
    data_byte  <= value;
    byte_valid <= 1'b1;
    @(posedge read_signal);
    while (!byte_ready)
      @(posedge read_signal);
  endtask

  task automatic run_header();
    int hold;
    ref_parse(hdr, exp_tb, exp_err, exp_pts, exp_dts);
    start <= 1'b1;
    foreach (hdr[i])
      send_byte(hdr[i]);
    while (!done)
      @(posedge read_signal);
    hold = $urandom_range(1, 3);
    data_byte  <= 8'h21; // offered while done is high, must stay unconsumed
    byte_valid <= 1'b1;
    repeat (hold)
    begin
      @(posedge read_signal);
      if (!done)
      begin
        drive_errors++;
        $display("%s: done fell while start was still high", test_name);
      end
    end
    start      <= 1'b0;
    byte_valid <= 1'b0;
    @(posedge read_signal);
    @(posedge read_signal);
    if (done)
    begin
      drive_errors++;
      $display("%s: done stayed high after start was seen low", test_name);
    end
    while (done)
      @(posedge read_signal);
  endtask

  always @(posedge read_signal)
  begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT)
    begin
      $display("timeout after %0d cycles, the parser never finished a header", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // outputs are sampled one edge after done rises
  always @(posedge read_signal)
  begin
    done_q <= done;
    if (done && byte_ready)
    begin
      check_errors++;
      $display("byte_ready is high while done is high");
    end
    if (done && !done_q)
    begin
      compared++;
      if (time_bytes !== exp_tb)
      begin
        check_errors++;
        $display("Fail %s time_bytes expected %0d actual %0d", test_name, exp_tb, time_bytes);
      end
      if (header_error !== exp_err)
      begin
        check_errors++;
        $display("Fail %s header_error expected %0b actual %0b", test_name, exp_err,
                 header_error);
      end
      if (pts !== exp_pts)
      begin
        check_errors++;
        $display("Fail %s pts expected %h actual %h", test_name, exp_pts, pts);
      end
      if (dts !== exp_dts)
      begin
        check_errors++;
        $display("Fail %s dts expected %h actual %h", test_name, exp_dts, dts);
      end
    end
  end

  initial
  begin
    void'($urandom(32'h4819_b979));
    read_signal  = 1'b0;
    rst          = 1'b1;
    start        = 1'b0;
    data_byte    = 8'h00;
    byte_valid   = 1'b0;
    done_q       = 1'b0;
    cycles       = 0;
    compared     = 0;
    check_errors = 0;
    drive_errors = 0;
    repeat (8) @(posedge read_signal);
    rst <= 1'b0;
    @(posedge read_signal);
    if (byte_ready !== 1'b0 || done !== 1'b0 || header_error !== 1'b0 ||
        time_bytes !== 4'd0)
    begin
      drive_errors++;
      $display("outputs are not in their reset state after reset");
    end
    for (int n = 0; n < NUM_HEADERS; n++)
    begin
      hdr.delete();
      ns = $urandom_range(0, MAX_STUFF);
      repeat (ns) hdr.push_back(8'hFF);
      case (n % 8)
        0, 1:
        begin
          test_name = "pts_only";
          add_field(4'b0010, rand_ts(), -1);
        end
        2, 3:
        begin
          test_name = "pts_dts";
          add_field(4'b0011, rand_ts(), -1);
          add_field(4'b0001, rand_ts(), -1);
        end
        4:
        begin
          test_name = "no_timestamp";
          hdr.push_back(8'h0F);
        end
        5:
        begin
          test_name = "stuffing_overflow";
          hdr.delete();
          repeat (MAX_STUFF + 1) hdr.push_back(8'hFF);
        end
        6:
        begin
          test_name = "unknown_first_byte";
          do
            b = 8'($urandom_range(0, 255));
          while (b == 8'hFF || b == 8'h0F || b[7:4] == 4'b0010 || b[7:4] == 4'b0011);
          hdr.push_back(b);
        end
        default:
        begin
          sub = $urandom_range(0, 2);
          if (sub == 0)
          begin
            test_name = "pts_marker";
            add_field(4'b0010, rand_ts(), $urandom_range(0, 2));
          end
          else if (sub == 1)
          begin
            test_name = "dts_marker";
            add_field(4'b0011, rand_ts(), -1);
            add_field(4'b0001, rand_ts(), $urandom_range(0, 2));
          end
          else
          begin
            test_name = "dts_prefix";
            nib = 4'($urandom_range(0, 15));
            if (nib == 4'b0001)
              nib = 4'b1001;
            add_field(4'b0011, rand_ts(), -1);
            add_field(nib, rand_ts(), -1);
          end
        end
      endcase
      run_header();
    end
    repeat (2) @(posedge read_signal);
    $display("headers %0d, check errors %0d, drive errors %0d", compared, check_errors,
             drive_errors);
    if (check_errors == 0 && drive_errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* src.f */
source/pes_pkg.sv
source/pes_byte_if.sv
source/header_byte_classifier.sv
source/timestamp_assembler.sv
source/header_sequencer.sv
source/pes_timestamp_parser.sv
bench/pes_timestamp_parser_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = pes_timestamp_parser_tb
FILELIST = src.f
OBJ_DIR  = obj_dir
PASS_MSG = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
